// File: rtl/mem_pkg.sv
`default_nettype none
/* widths, byte-address and beat types, access size enum
   requester and routed request structs, response struct, strobe helper */
package mem_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;

  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W,
    SIZE_D
  } access_size_e;

  // fetch address is always 8-byte aligned
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  // wdata already sits in the lanes picked by addr
  typedef struct packed {
    addr_t        addr;
    logic         wen;
    access_size_e size;
    data_t        wdata;
  } lsu_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } mem_rsp_t;

  typedef enum logic {
    ROUTE_TIMER,
    ROUTE_BUS
  } route_e;

  typedef struct packed {
    addr_t        addr;
    logic         wen;
    access_size_e size;
    data_t        wdata;
  } bus_req_t;

  // byte enables for one access inside the beat
  function automatic strb_t size_strb(access_size_e size, logic [2:0] off);
    strb_t base;
    case (size)
      SIZE_B:  base = strb_t'(1);
      SIZE_H:  base = strb_t'(3);
      SIZE_W:  base = strb_t'(15);
      default: base = '1;
    endcase
    return base << off;
  endfunction

endpackage
`default_nettype wire

// File: rtl/axi_pkg.sv
`default_nettype none
/* AXI4-Lite channel payload structs and response codes */
package axi_pkg;

  import mem_pkg::*;

  typedef logic [2:0] prot_t;

  // only OKAY and SLVERR are ever produced or expected
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } axi_aw_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } axi_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axi_w_t;

  typedef struct packed {
    axi_resp_e resp;
  } axi_b_t;

  typedef struct packed {
    data_t     data;
    axi_resp_e resp;
  } axi_r_t;

endpackage
`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
/* fixed-priority arbiter for fetch and load/store requests
   routes the granted request to the timer window or the bus master */
module mem_arbiter import mem_pkg::*; #(
  parameter addr_t TIMER_BASE = 32'h0200_0000
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             i_fetch_valid,
  input  wire fetch_req_t i_fetch_req,
  output logic            o_fetch_ready,
  input  wire             i_lsu_valid,
  input  wire lsu_req_t   i_lsu_req,
  output logic            o_lsu_ready,
  output mem_rsp_t        o_rsp,
  output logic            o_timer_sel,
  output bus_req_t        o_bus_req,
  output logic            o_bus_valid,
  input  wire             i_bus_ready,
  input  wire             i_bus_rsp_valid,
  input  wire mem_rsp_t   i_bus_rsp,
  input  wire data_t      i_timer_rdata
);

  typedef enum logic [1:0] {
    IDLE,
    TIMER,
    BUS
  } arb_state_e;

  arb_state_e state_q;
  logic       owner_lsu_q;
  logic       timer_ack_q;
  logic       bus_sent_q;
  bus_req_t   req_q;
  bus_req_t   sel_req;
  addr_t      win_off;
  route_e     route;
  logic       take;
  logic       done;

  // load/store wins over fetch
  always_comb begin
    if (i_lsu_valid) begin
      sel_req = '{addr: i_lsu_req.addr, wen: i_lsu_req.wen,
                  size: i_lsu_req.size, wdata: i_lsu_req.wdata};
    end else begin
      sel_req = '{addr: i_fetch_req.addr, wen: 1'b0, size: SIZE_D, wdata: '0};
    end
  end

  assign take    = i_lsu_valid | i_fetch_valid;
  assign win_off = sel_req.addr - TIMER_BASE;
  assign route   = (win_off < addr_t'(16)) ? ROUTE_TIMER : ROUTE_BUS;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      owner_lsu_q <= 1'b0;
      timer_ack_q <= 1'b0;
      bus_sent_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (take) begin
            owner_lsu_q <= i_lsu_valid;
            state_q     <= (route == ROUTE_TIMER) ? TIMER : BUS;
          end
        end
        // select cycle, then ack cycle
        TIMER: begin
          timer_ack_q <= ~timer_ack_q;
          if (timer_ack_q) begin
            state_q <= IDLE;
          end
        end
        BUS: begin
          if (o_bus_valid && i_bus_ready) begin
            bus_sent_q <= 1'b1;
          end
          if (i_bus_rsp_valid) begin
            bus_sent_q <= 1'b0;
            state_q    <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && take) begin
      req_q <= sel_req;
    end
  end

  assign done = (state_q == TIMER && timer_ack_q) || (state_q == BUS && i_bus_rsp_valid);

  assign o_lsu_ready   = done & owner_lsu_q;
  assign o_fetch_ready = done & ~owner_lsu_q;
  assign o_rsp         = (state_q == TIMER) ? mem_rsp_t'{rdata: i_timer_rdata, err: 1'b0}
                                            : i_bus_rsp;
  assign o_timer_sel   = (state_q == TIMER) && !timer_ack_q;
  assign o_bus_req     = req_q;
  assign o_bus_valid   = (state_q == BUS) && !bus_sent_q;

endmodule
`default_nettype wire

// File: rtl/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none
/* core-local timer with mtime and mtimecmp registers
   byte-lane writes and a registered timer interrupt compare */
module clint_timer import mem_pkg::*; (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           i_sel,
  input  wire bus_req_t i_req,
  output data_t         o_rdata,
  output logic          o_timer_int
);

  data_t mtime_q;
  data_t mtimecmp_q;
  data_t wmask;
  strb_t lanes;
  logic  wr_time;
  logic  wr_cmp;

  always_comb begin
    lanes = size_strb(i_req.size, i_req.addr[2:0]);
    for (int i = 0; i < DATA_W/8; i++) begin
      wmask[i*8 +: 8] = {8{lanes[i]}};
    end
  end

  // offset 0 is mtime, offset 8 is mtimecmp
  assign wr_time = i_sel & i_req.wen & ~i_req.addr[3];
  assign wr_cmp  = i_sel & i_req.wen & i_req.addr[3];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      o_timer_int <= 1'b0;
    end else begin
      // a write replaces this cycle's increment
      if (wr_time) begin
        mtime_q <= (mtime_q & ~wmask) | (i_req.wdata & wmask);
      end else begin
        mtime_q <= mtime_q + data_t'(1);
      end
      if (wr_cmp) begin
        mtimecmp_q <= (mtimecmp_q & ~wmask) | (i_req.wdata & wmask);
      end
      o_timer_int <= (mtime_q >= mtimecmp_q);
    end
  end

  assign o_rdata = i_req.addr[3] ? mtimecmp_q : mtime_q;

endmodule
`default_nettype wire

// File: rtl/axi_lite_master.sv
`timescale 1ns/1ps
`default_nettype none
/* single-beat AXI4-Lite master for routed bus requests
   write via aw/w/b, read via ar/r, error on any non-OKAY response */
module axi_lite_master import mem_pkg::*, axi_pkg::*; (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           i_req_valid,
  input  wire bus_req_t i_req,
  output logic          o_req_ready,
  output logic          o_rsp_valid,
  output mem_rsp_t      o_rsp,
  output axi_aw_t       o_aw,
  output logic          o_aw_valid,
  input  wire           i_aw_ready,
  output axi_w_t        o_w,
  output logic          o_w_valid,
  input  wire           i_w_ready,
  input  wire axi_b_t   i_b,
  input  wire           i_b_valid,
  output logic          o_b_ready,
  output axi_ar_t       o_ar,
  output logic          o_ar_valid,
  input  wire           i_ar_ready,
  input  wire axi_r_t   i_r,
  input  wire           i_r_valid,
  output logic          o_r_ready
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    WRESP,
    READ
  } axi_state_e;

  axi_state_e state_q;
  bus_req_t   req_q;
  logic       addr_done_q;
  logic       w_done_q;
  logic       addr_fin;
  logic       w_fin;

  // aw (or ar) and w finish independently
  assign addr_fin = addr_done_q | (o_aw_valid & i_aw_ready);
  assign w_fin    = w_done_q | (o_w_valid & i_w_ready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      addr_done_q <= 1'b0;
      w_done_q    <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          addr_done_q <= 1'b0;
          w_done_q    <= 1'b0;
          if (i_req_valid) begin
            state_q <= i_req.wen ? WRITE : READ;
          end
        end
        WRITE: begin
          addr_done_q <= addr_fin;
          w_done_q    <= w_fin;
          if (addr_fin && w_fin) begin
            state_q <= WRESP;
          end
        end
        WRESP: begin
          if (i_b_valid) begin
            state_q <= IDLE;
          end
        end
        READ: begin
          if (o_ar_valid && i_ar_ready) begin
            addr_done_q <= 1'b1;
          end
          if (o_r_ready && i_r_valid) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && i_req_valid) begin
      req_q <= i_req;
    end
  end

  assign o_req_ready = (state_q == IDLE);

  assign o_aw       = '{addr: req_q.addr, prot: '0};
  assign o_aw_valid = (state_q == WRITE) && !addr_done_q;
  assign o_w        = '{data: req_q.wdata, strb: size_strb(req_q.size, req_q.addr[2:0])};
  assign o_w_valid  = (state_q == WRITE) && !w_done_q;
  assign o_b_ready  = (state_q == WRESP);

  assign o_ar       = '{addr: req_q.addr, prot: '0};
  assign o_ar_valid = (state_q == READ) && !addr_done_q;
  assign o_r_ready  = (state_q == READ) && addr_done_q;

  always_comb begin
    if (state_q == READ) begin
      o_rsp_valid = o_r_ready & i_r_valid;
      o_rsp       = '{rdata: i_r.data, err: (i_r.resp != RESP_OKAY)};
    end else begin
      o_rsp_valid = o_b_ready & i_b_valid;
      o_rsp       = '{rdata: '0, err: (i_b.resp != RESP_OKAY)};
    end
  end

endmodule
`default_nettype wire

// File: rtl/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none
/* memory subsystem top with arbiter, core-local timer and AXI4-Lite master */
module mem_subsys_top import mem_pkg::*, axi_pkg::*; #(
  parameter addr_t TIMER_BASE = 32'h0200_0000
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             i_fetch_valid,
  input  wire fetch_req_t i_fetch_req,
  output logic            o_fetch_ready,
  input  wire             i_lsu_valid,
  input  wire lsu_req_t   i_lsu_req,
  output logic            o_lsu_ready,
  output mem_rsp_t        o_rsp,
  output axi_aw_t         o_aw,
  output logic            o_aw_valid,
  input  wire             i_aw_ready,
  output axi_w_t          o_w,
  output logic            o_w_valid,
  input  wire             i_w_ready,
  input  wire axi_b_t     i_b,
  input  wire             i_b_valid,
  output logic            o_b_ready,
  output axi_ar_t         o_ar,
  output logic            o_ar_valid,
  input  wire             i_ar_ready,
  input  wire axi_r_t     i_r,
  input  wire             i_r_valid,
  output logic            o_r_ready,
  output logic            o_timer_int
);

  bus_req_t bus_req;
  logic     bus_valid;
  logic     bus_ready;
  logic     bus_rsp_valid;
  mem_rsp_t bus_rsp;
  logic     timer_sel;
  data_t    timer_rdata;

  mem_arbiter #(
    .TIMER_BASE (TIMER_BASE)
  ) u_arbiter (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_fetch_valid   (i_fetch_valid),
    .i_fetch_req     (i_fetch_req),
    .o_fetch_ready   (o_fetch_ready),
    .i_lsu_valid     (i_lsu_valid),
    .i_lsu_req       (i_lsu_req),
    .o_lsu_ready     (o_lsu_ready),
    .o_rsp           (o_rsp),
    .o_timer_sel     (timer_sel),
    .o_bus_req       (bus_req),
    .o_bus_valid     (bus_valid),
    .i_bus_ready     (bus_ready),
    .i_bus_rsp_valid (bus_rsp_valid),
    .i_bus_rsp       (bus_rsp),
    .i_timer_rdata   (timer_rdata)
  );

  clint_timer u_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_sel       (timer_sel),
    .i_req       (bus_req),
    .o_rdata     (timer_rdata),
    .o_timer_int (o_timer_int)
  );

  axi_lite_master u_axi_master (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_req_valid (bus_valid),
    .i_req       (bus_req),
    .o_req_ready (bus_ready),
    .o_rsp_valid (bus_rsp_valid),
    .o_rsp       (bus_rsp),
    .o_aw        (o_aw),
    .o_aw_valid  (o_aw_valid),
    .i_aw_ready  (i_aw_ready),
    .o_w         (o_w),
    .o_w_valid   (o_w_valid),
    .i_w_ready   (i_w_ready),
    .i_b         (i_b),
    .i_b_valid   (i_b_valid),
    .o_b_ready   (o_b_ready),
    .o_ar        (o_ar),
    .o_ar_valid  (o_ar_valid),
    .i_ar_ready  (i_ar_ready),
    .i_r         (i_r),
    .i_r_valid   (i_r_valid),
    .o_r_ready   (o_r_ready)
  );

endmodule
`default_nettype wire

// File: verification/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none
/* AXI4-Lite slave with a memory array, random ready delays
   and SLVERR for addresses with the error bit set */
module axi_slave_model import mem_pkg::*, axi_pkg::*; #(
  parameter addr_t MEM_BASE = 32'h8000_0000,
  parameter int    ERR_BIT  = 12
) (
  input  wire           clk,
  input  wire           rst_n,
  input  wire [1:0]     i_delay,
  input  wire axi_aw_t  i_aw,
  input  wire           i_aw_valid,
  output logic          o_aw_ready,
  input  wire axi_w_t   i_w,
  input  wire           i_w_valid,
  output logic          o_w_ready,
  output axi_b_t        o_b,
  output logic          o_b_valid,
  input  wire           i_b_ready,
  input  wire axi_ar_t  i_ar,
  input  wire           i_ar_valid,
  output logic          o_ar_ready,
  output axi_r_t        o_r,
  output logic          o_r_valid,
  input  wire           i_r_ready
);

  data_t      mem [512];
  logic [1:0] wwait;
  logic [1:0] rwait;

  function automatic axi_resp_e resp_for(addr_t a);
    return a[ERR_BIT] ? RESP_SLVERR : RESP_OKAY;
  endfunction

  // fill word built from its own full address
  initial begin
    addr_t a;
    for (int i = 0; i < 512; i++) begin
      a = MEM_BASE | (addr_t'(i) << 3);
      mem[i] = {~a, a};
    end
    o_aw_ready = 1'b0;
    o_w_ready  = 1'b0;
    o_b_valid  = 1'b0;
    o_b        = '{resp: RESP_OKAY};
    o_ar_ready = 1'b0;
    o_r_valid  = 1'b0;
    o_r        = '{data: '0, resp: RESP_OKAY};
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      o_aw_ready <= 1'b0;
      o_w_ready  <= 1'b0;
      o_b_valid  <= 1'b0;
      o_ar_ready <= 1'b0;
      o_r_valid  <= 1'b0;
      wwait      <= 2'd0;
      rwait      <= 2'd0;
    end else begin
      o_aw_ready <= 1'b0;
      o_w_ready  <= 1'b0;
      o_ar_ready <= 1'b0;
      if (o_b_valid && i_b_ready) begin
        o_b_valid <= 1'b0;
      end
      if (o_r_valid && i_r_ready) begin
        o_r_valid <= 1'b0;
      end
      // aw and w accepted together after the drawn delay
      if (i_aw_valid && i_w_valid && !o_aw_ready && !o_b_valid) begin
        if (wwait == 2'd0) begin
          o_aw_ready <= 1'b1;
          o_w_ready  <= 1'b1;
          wwait      <= i_delay;
        end else begin
          wwait <= wwait - 2'd1;
        end
      end
      if (i_aw_valid && o_aw_ready) begin
        if (!i_aw.addr[ERR_BIT]) begin
          for (int lane = 0; lane < 8; lane++) begin
            if (i_w.strb[lane]) begin
              mem[i_aw.addr[11:3]][lane*8 +: 8] <= i_w.data[lane*8 +: 8];
            end
          end
        end
        o_b       <= '{resp: resp_for(i_aw.addr)};
        o_b_valid <= 1'b1;
      end
      if (i_ar_valid && !o_ar_ready && !o_r_valid) begin
        if (rwait == 2'd0) begin
          o_ar_ready <= 1'b1;
          rwait      <= i_delay;
        end else begin
          rwait <= rwait - 2'd1;
        end
      end
      if (i_ar_valid && o_ar_ready) begin
        o_r.data  <= i_ar.addr[ERR_BIT] ? '0 : mem[i_ar.addr[11:3]];
        o_r.resp  <= resp_for(i_ar.addr);
        o_r_valid <= 1'b1;
      end
    end
  end

endmodule
`default_nettype wire

// File: verification/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none
/* testbench for the memory subsystem with LFSR stimulus,
   shadow memory model, compare tasks and watchdog */
module tb_mem_subsys import mem_pkg::*, axi_pkg::*; ();

  localparam logic [31:0] SEED       = 32'hd846_c815;
  localparam int          N_MEM      = 240;
  localparam int          ERR_BIT    = 12;
  localparam addr_t       MEM_BASE   = 32'h8000_0000;
  localparam addr_t       TIMER_BASE = 32'h0200_0000;
  localparam int          WATCHDOG   = (N_MEM + 16) * 64;

  logic       clk;
  logic       rst_n;
  logic       fetch_valid;
  fetch_req_t fetch_req;
  logic       fetch_ready;
  logic       lsu_valid;
  lsu_req_t   lsu_req;
  logic       lsu_ready;
  mem_rsp_t   rsp;
  axi_aw_t    aw;
  logic       aw_valid;
  logic       aw_ready;
  axi_w_t     w;
  logic       w_valid;
  logic       w_ready;
  axi_b_t     b;
  logic       b_valid;
  logic       b_ready;
  axi_ar_t    ar;
  logic       ar_valid;
  logic       ar_ready;
  axi_r_t     r;
  logic       r_valid;
  logic       r_ready;
  logic       timer_int;
  logic [1:0] slave_delay;
  logic [31:0] lfsr;
  logic       in_timer;
  int         errors;
  data_t      shadow [int];

  mem_subsys_top #(
    .TIMER_BASE (TIMER_BASE)
  ) uut (
    .clk (clk), .rst_n (rst_n),
    .i_fetch_valid (fetch_valid), .i_fetch_req (fetch_req), .o_fetch_ready (fetch_ready),
    .i_lsu_valid (lsu_valid), .i_lsu_req (lsu_req), .o_lsu_ready (lsu_ready),
    .o_rsp (rsp),
    .o_aw (aw), .o_aw_valid (aw_valid), .i_aw_ready (aw_ready),
    .o_w (w), .o_w_valid (w_valid), .i_w_ready (w_ready),
    .i_b (b), .i_b_valid (b_valid), .o_b_ready (b_ready),
    .o_ar (ar), .o_ar_valid (ar_valid), .i_ar_ready (ar_ready),
    .i_r (r), .i_r_valid (r_valid), .o_r_ready (r_ready),
    .o_timer_int (timer_int)
  );

  axi_slave_model #(
    .MEM_BASE (MEM_BASE),
    .ERR_BIT  (ERR_BIT)
  ) u_slave (
    .clk (clk), .rst_n (rst_n), .i_delay (slave_delay),
    .i_aw (aw), .i_aw_valid (aw_valid), .o_aw_ready (aw_ready),
    .i_w (w), .i_w_valid (w_valid), .o_w_ready (w_ready),
    .o_b (b), .o_b_valid (b_valid), .i_b_ready (b_ready),
    .i_ar (ar), .i_ar_valid (ar_valid), .o_ar_ready (ar_ready),
    .o_r (r), .o_r_valid (r_valid), .i_r_ready (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic data_t shadow_read(int idx);
    addr_t a;
    a = MEM_BASE | (addr_t'(idx) << 3);
    return shadow.exists(idx) ? shadow[idx] : {~a, a};
  endfunction

  task automatic fail_value(string msg);
    errors++;
    $display("Fail at %0t ns: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic fail_other(string msg);
    errors++;
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_rsp(mem_rsp_t got, mem_rsp_t exp, string what);
    if (got !== exp) begin
      fail_value($sformatf("%s: got %h/%b, expected %h/%b",
                           what, got.rdata, got.err, exp.rdata, exp.err));
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp) begin
      fail_value($sformatf("%s: got %b, expected %b", what, got, exp));
    end
  endtask

  task automatic apply_write(int idx, access_size_e sz, logic [2:0] boff, data_t wd);
    data_t v;
    v = shadow_read(idx);
    for (int lane = 0; lane < 8; lane++) begin
      if (lane >= int'(boff) && lane < int'(boff) + (1 << int'(sz))) begin
        v[lane*8 +: 8] = wd[lane*8 +: 8];
      end
    end
    shadow[idx] = v;
  endtask

  // raise one or both ports, collect each response and its cycle count
  task automatic run_pair(input logic do_lsu, input logic do_fetch,
                          input lsu_req_t lr, input fetch_req_t fr,
                          output mem_rsp_t lrsp, output mem_rsp_t frsp,
                          output int lcyc, output int fcyc);
    logic lpend;
    logic fpend;
    int   cyc;
    @(posedge clk);
    lsu_valid   <= do_lsu;
    lsu_req     <= lr;
    fetch_valid <= do_fetch;
    fetch_req   <= fr;
    lpend = do_lsu;
    fpend = do_fetch;
    cyc   = 0;
    lcyc  = 0;
    fcyc  = 0;
    while (lpend || fpend) begin
      @(negedge clk);
      cyc++;
      if (lsu_ready && lpend) begin
        lrsp  = rsp;
        lcyc  = cyc;
        lpend = 1'b0;
      end
      if (fetch_ready && fpend) begin
        frsp  = rsp;
        fcyc  = cyc;
        fpend = 1'b0;
      end
      @(posedge clk);
      if (!lpend) lsu_valid <= 1'b0;
      if (!fpend) fetch_valid <= 1'b0;
    end
  endtask

  task automatic timer_op(addr_t a, logic wen, data_t wd, output mem_rsp_t got);
    lsu_req_t   lr;
    fetch_req_t fr;
    mem_rsp_t   unused;
    int         lcyc;
    int         fcyc;
    lr = '{addr: a, wen: wen, size: SIZE_D, wdata: wd};
    fr = '{addr: '0};
    run_pair(1'b1, 1'b0, lr, fr, got, unused, lcyc, fcyc);
    if (lcyc != 3) begin
      fail_value($sformatf("timer ready after %0d cycles", lcyc));
    end
  endtask

  // ready without a request, or AXI traffic during a timer access
  always @(negedge clk) begin
    if (rst_n) begin
      if (lsu_ready && !lsu_valid) fail_other("load/store ready without a request");
      if (fetch_ready && !fetch_valid) fail_other("fetch ready without a request");
      if (in_timer && (aw_valid || w_valid || ar_valid)) begin
        fail_other("AXI valid raised during a timer access");
      end
      slave_delay = 2'(rand_bits(2));
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog timeout: the run did not finish in time");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    int           kind;
    int           idx;
    int           fidx;
    int           lcyc;
    int           fcyc;
    int           k;
    int           cnt;
    logic         e;
    logic         fe;
    logic         do_lsu;
    logic         do_fetch;
    access_size_e sz;
    logic [2:0]   boff;
    addr_t        a;
    data_t        v;
    data_t        x;
    lsu_req_t     lr;
    fetch_req_t   fr;
    mem_rsp_t     lrsp;
    mem_rsp_t     frsp;
    lfsr        = SEED;
    errors      = 0;
    in_timer    = 1'b0;
    slave_delay = 2'd0;
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    fetch_req   = '0;
    lsu_valid   = 1'b0;
    lsu_req     = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // kind 0 write, 1 read, 2 fetch, 3 both ports at once
    for (int n = 0; n < N_MEM; n++) begin
      kind = int'(rand_bits(2));
      e    = (rand_bits(3) == 0);
      idx  = int'(rand_bits(9));
      sz   = access_size_e'(rand_bits(2));
      boff = 3'(rand_bits(3)) & ~3'((1 << int'(sz)) - 1);
      a    = MEM_BASE | (addr_t'(e) << ERR_BIT) | (addr_t'(idx) << 3) | addr_t'(boff);
      lr   = '{addr: a, wen: (kind == 0) || (kind == 3 && rand_bits(1) == 1),
               size: sz, wdata: rand_bits(64)};
      fe   = (rand_bits(3) == 0);
      fidx = int'(rand_bits(9));
      fr   = '{addr: MEM_BASE | (addr_t'(fe) << ERR_BIT) | (addr_t'(fidx) << 3)};
      do_lsu   = (kind != 2);
      do_fetch = (kind >= 2);
      run_pair(do_lsu, do_fetch, lr, fr, lrsp, frsp, lcyc, fcyc);
      if (do_lsu && lr.wen) begin
        check_bit(lrsp.err, e, "store error flag");
        if (!e) apply_write(idx, sz, boff, lr.wdata);
      end else if (do_lsu && e) begin
        check_bit(lrsp.err, 1'b1, "load error flag");
      end else if (do_lsu) begin
        check_rsp(lrsp, '{rdata: shadow_read(idx), err: 1'b0}, "load data");
      end
      if (do_fetch && fe) begin
        check_bit(frsp.err, 1'b1, "fetch error flag");
      end else if (do_fetch) begin
        check_rsp(frsp, '{rdata: shadow_read(fidx), err: 1'b0}, "fetch data");
      end
      if (kind == 3 && lcyc >= fcyc) fail_other("fetch was served before load/store");
    end

    in_timer = 1'b1;
    v = rand_bits(64) | 64'h8000_0000_0000_0000;
    timer_op(TIMER_BASE + 8, 1'b1, v, lrsp);
    timer_op(TIMER_BASE + 8, 1'b0, '0, lrsp);
    check_rsp(lrsp, '{rdata: v, err: 1'b0}, "mtimecmp readback");

    x = 64'h1000_0000_0000_0000 | rand_bits(32);
    k = 4 + int'(rand_bits(3));
    timer_op(TIMER_BASE + 8, 1'b1, x + data_t'(k), lrsp);
    timer_op(TIMER_BASE, 1'b1, x, lrsp);
    @(negedge clk);
    check_bit(timer_int, 1'b0, "interrupt right after mtime write");
    cnt = 1;
    while (!timer_int) begin
      @(negedge clk);
      cnt++;
      if (cnt > k + 4) fail_value($sformatf("interrupt not raised within %0d cycles", k + 4));
    end
    in_timer = 1'b0;

    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
`default_nettype wire

// File: compile.f
rtl/mem_pkg.sv
rtl/axi_pkg.sv
rtl/mem_arbiter.sv
rtl/clint_timer.sv
rtl/axi_lite_master.sv
rtl/mem_subsys_top.sv
verification/axi_slave_model.sv
verification/tb_mem_subsys.sv

// File: Makefile
# Verilator flow for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
